// ==== all.f ====
+incdir+common
common/csr_pkg.sv
verilog/csr_op_decode.sv
trap/priv_trap_fsm.sv
trap/trap_regs.sv
perf/perf_counters.sv
verilog/csr_unit_top.sv
sim/tb_clk_gen.sv
sim/csr_unit_tb.sv

// ==== common/csr_macros.svh ====
////////////////////////////////////////
// csr addresses, mstatus bit positions
// and counter bank sizing
////////////////////////////////////////

`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define CSR_XLEN 32

// user level
`define CSR_USTATUS   12'h000
`define CSR_UHARTID   12'h014
// machine level
`define CSR_MSTATUS   12'h300
`define CSR_MISA      12'h301
`define CSR_MTVEC     12'h305
`define CSR_MEPC      12'h341
`define CSR_MCAUSE    12'h342
`define CSR_MVENDORID 12'hF11
`define CSR_MARCHID   12'hF12
`define CSR_MIMPID    12'hF13
`define CSR_MHARTID   12'hF14
`define CSR_PRIVLV    12'hC10
// performance counter block
`define CSR_PCCR_BASE 12'h780
`define CSR_PCCR_ALL  12'h79F
`define CSR_PCER      12'h7A0
`define CSR_PCMR      12'h7A1

// mstatus field positions
`define MSTATUS_UIE    0
`define MSTATUS_MIE    3
`define MSTATUS_UPIE   4
`define MSTATUS_MPIE   7
`define MSTATUS_MPP_LO 11
`define MSTATUS_MPP_HI 12

`define PERF_N_CNT 8
// enable and saturate
`define PCMR_RESET 2'b11

`endif

// ==== common/csr_pkg.sv ====
////////////////////////////////////////
// types shared by the csr unit blocks
// only U and M privilege levels exist
////////////////////////////////////////

package csr_pkg;

  // privilege level, encoded as in the spec
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_t;

  // csr instruction operation
  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_t;

  // implemented mstatus bits only
  typedef struct packed {
    logic      uie;
    logic      mie;
    logic      upie;
    logic      mpie;
    priv_lvl_t mpp;
  } mstatus_t;

  // one-hot register selects from the decoder
  typedef struct packed {
    logic       mstatus;
    logic       ustatus;
    logic       mtvec;
    logic       mepc;
    logic       mcause;
    logic       pccr;
    logic       pccr_all;
    logic       pcer;
    logic       pcmr;
    // counter number, low bits of the address
    logic [4:0] cnt_idx;
  } csr_sel_t;

  // trap and return requests from the controller
  typedef struct packed {
    logic        save_cause;
    logic        save_if;
    logic        save_id;
    logic        restore_mret;
    // bit 5 set for interrupts
    logic [5:0]  cause;
    logic [31:0] pc_if;
    logic [31:0] pc_id;
  } trap_req_t;

  // raw event levels from the pipeline
  typedef struct packed {
    logic id_valid;
    logic is_decoding;
    logic ld_stall;
    logic jump;
    logic branch;
    logic branch_taken;
    logic mem_load;
    logic mem_store;
  } perf_events_t;

endpackage

// ==== perf/perf_counters.sv ====
////////////////////////////////////////
// performance counter bank
// count shows two cycles after the event
// a csr write beats that cycle's count
////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module perf_counters import csr_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  perf_events_t           perf_i,
  input  csr_sel_t               sel_i,
  input  logic                   wr_en_i,
  input  logic [`CSR_XLEN-1:0]   wdata_i,
  output logic [`PERF_N_CNT-1:0] pcer_o,
  output logic [1:0]             pcmr_o,
  output logic [`CSR_XLEN-1:0]   pccr_rdata_o
);

  localparam int N_CNT = `PERF_N_CNT;
  localparam int IDX_W = $clog2(N_CNT);

  logic                                id_valid_q;
  logic [N_CNT-1:0]                    evt;
  logic [N_CNT-1:0]                    inc;
  logic [N_CNT-1:0]                    inc_q;
  logic [N_CNT-1:0]                    pcer_q;
  logic [1:0]                          pcmr_q;
  logic [N_CNT-1:0][`CSR_XLEN-1:0]     cnt_q;
  logic [N_CNT-1:0][`CSR_XLEN-1:0]     cnt_n;

  ////////////////////////////////////////
  // event sources
  ////////////////////////////////////////

  // cycles
  assign evt[0] = 1'b1;
  // retired instructions
  assign evt[1] = perf_i.id_valid & perf_i.is_decoding;
  // stall, jump and branch pair with last cycle's id_valid
  assign evt[2] = perf_i.ld_stall & id_valid_q;
  assign evt[3] = perf_i.jump & id_valid_q;
  assign evt[4] = perf_i.branch & id_valid_q;
  assign evt[5] = perf_i.branch & perf_i.branch_taken & id_valid_q;
  // memory traffic
  assign evt[6] = perf_i.mem_load;
  assign evt[7] = perf_i.mem_store;

  // per-counter enable and global enable
  assign inc = evt & pcer_q & {N_CNT{pcmr_q[0]}};

  ////////////////////////////////////////
  // counter update
  ////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < N_CNT; i++) begin
      cnt_n[i] = cnt_q[i];
      // hold at all ones when saturating
      if (inc_q[i] && (!(&cnt_q[i]) || !pcmr_q[1])) begin
        cnt_n[i] = cnt_q[i] + 1'b1;
      end
      if (wr_en_i && (sel_i.pccr_all || (sel_i.pccr && (int'(sel_i.cnt_idx) == i)))) begin
        cnt_n[i] = wdata_i;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_valid_q <= 1'b0;
      inc_q      <= '0;
      cnt_q      <= '0;
    end else begin
      id_valid_q <= perf_i.id_valid;
      inc_q      <= inc;
      cnt_q      <= cnt_n;
    end
  end

  // mask and mode registers
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= `PCMR_RESET;
    end else begin
      if (wr_en_i && sel_i.pcer) begin
        pcer_q <= wdata_i[N_CNT-1:0];
      end
      // bit 0 enable, bit 1 saturate
      if (wr_en_i && sel_i.pcmr) begin
        pcmr_q <= wdata_i[1:0];
      end
    end
  end

  assign pcer_o = pcer_q;
  assign pcmr_o = pcmr_q;

  // indices past the bank read 0
  always_comb begin
    pccr_rdata_o = '0;
    if (int'(sel_i.cnt_idx) < N_CNT) begin
      pccr_rdata_o = cnt_q[sel_i.cnt_idx[IDX_W-1:0]];
    end
  end

endmodule

// ==== sim/csr_unit_tb.sv ====
////////////////////////////////////////
// csr unit testbench, random stimulus
// inputs change 1 ns after the rising edge
// outputs sampled 3 ns after it
////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_unit_tb import csr_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  // cycle budgets of the five tests
  localparam int BUDGET     = 40 + 200 + 320 + 300 + 120;
  localparam int MARGIN     = 100;
  localparam logic [11:0] PCCR_BASE  = `CSR_PCCR_BASE;
  localparam logic [3:0]  CORE_ID    = 4'h5;
  localparam logic [5:0]  CLUSTER_ID = 6'h2a;
  // cluster 0x2a in bits 10:5, core 5 in bits 3:0
  localparam logic [31:0] HARTID_EXP = 32'h0000_0545;

  logic         clk;
  logic         rst_n;
  logic         acc;
  logic [11:0]  addr;
  csr_op_t      op;
  logic [31:0]  wdata;
  trap_req_t    trap;
  perf_events_t perf;
  logic [31:0]  csr_rdata;
  priv_lvl_t    priv_lvl;
  logic         m_irq_en;
  logic         u_irq_en;
  logic [31:0]  epc;
  logic [23:0]  mtvec;

  ////////////////////////////////////////
  // reference model state
  ////////////////////////////////////////

  logic [1:0]  m_priv;
  logic        m_uie;
  logic        m_mie;
  logic        m_upie;
  logic        m_mpie;
  logic [1:0]  m_mpp;
  logic [31:0] m_mepc;
  logic [5:0]  m_mcause;
  logic [23:0] m_mtvec;
  logic [7:0]  m_pcer;
  logic [1:0]  m_pcmr;
  logic [31:0] m_cnt [0:7];
  // event pipeline, two cycles to the counter
  logic        m_idv_q;
  logic [7:0]  m_inc_q;

  int          err_cnt;
  int          check_cnt;
  int          test_cnt;
  int          test_err_start;
  int          seed_ret;
  logic [31:0] last_rdata;
  logic [31:0] held;

  logic [11:0] reg_addrs [0:4] = '{`CSR_USTATUS, `CSR_MSTATUS, `CSR_MTVEC,
                                   `CSR_MEPC, `CSR_MCAUSE};
  logic [11:0] trap_addrs [0:4] = '{`CSR_MSTATUS, `CSR_USTATUS, `CSR_MEPC,
                                    `CSR_MCAUSE, `CSR_PRIVLV};

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(4)) u_clk_gen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  csr_unit_top u_csr_unit_top (
    .clk            (clk),
    .rst_n          (rst_n),
    .csr_access_i   (acc),
    .csr_addr_i     (addr),
    .csr_op_i       (op),
    .csr_wdata_i    (wdata),
    .csr_rdata_o    (csr_rdata),
    .trap_i         (trap),
    .perf_i         (perf),
    .core_id_i      (CORE_ID),
    .cluster_id_i   (CLUSTER_ID),
    .priv_lvl_o     (priv_lvl),
    .m_irq_enable_o (m_irq_en),
    .u_irq_enable_o (u_irq_en),
    .epc_o          (epc),
    .mtvec_o        (mtvec)
  );

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // expected read value from the model
  function automatic logic [31:0] exp_rdata(input logic a, input logic [11:0] ad);
    logic [31:0] r;
    r = '0;
    if (a) begin
      case (ad)
        `CSR_USTATUS: begin
          r[`MSTATUS_UIE]  = m_uie;
          r[`MSTATUS_UPIE] = m_upie;
        end
        `CSR_MSTATUS: begin
          r[`MSTATUS_UIE]  = m_uie;
          r[`MSTATUS_MIE]  = m_mie;
          r[`MSTATUS_UPIE] = m_upie;
          r[`MSTATUS_MPIE] = m_mpie;
          r[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = m_mpp;
        end
        `CSR_MTVEC:   r = {m_mtvec, 8'h00};
        `CSR_MEPC:    r = m_mepc;
        `CSR_MCAUSE:  r = {m_mcause[5], 26'b0, m_mcause[4:0]};
        `CSR_MHARTID, `CSR_UHARTID: r = HARTID_EXP;
        `CSR_PRIVLV:  r = {30'b0, m_priv};
        `CSR_PCER:    r = {24'b0, m_pcer};
        `CSR_PCMR:    r = {30'b0, m_pcmr};
        default: begin
          // counter window, whole-bank address reads 0
          if (ad[11:5] == PCCR_BASE[11:5] && ad[4:0] < `PERF_N_CNT) begin
            r = m_cnt[ad[2:0]];
          end
        end
      endcase
    end
    return r;
  endfunction

  // one rising edge of the model, all from the old state
  task automatic model_update();
    logic [31:0] rd;
    logic [31:0] wd;
    logic        wr;
    logic [7:0]  evt;
    logic [7:0]  new_inc;
    rd = exp_rdata(acc, addr);
    wr = acc && (op != CSR_OP_NONE);
    case (op)
      CSR_OP_SET:   wd = rd | wdata;
      CSR_OP_CLEAR: wd = rd & ~wdata;
      default:      wd = wdata;
    endcase
    evt = {perf.mem_store, perf.mem_load,
           perf.branch & perf.branch_taken & m_idv_q, perf.branch & m_idv_q,
           perf.jump & m_idv_q, perf.ld_stall & m_idv_q,
           perf.id_valid & perf.is_decoding, 1'b1};
    new_inc = evt & m_pcer & {8{m_pcmr[0]}};
    for (int i = 0; i < 8; i++) begin
      if (m_inc_q[i] && !(m_cnt[i] == 32'hffff_ffff && m_pcmr[1])) begin
        m_cnt[i] = m_cnt[i] + 1;
      end
      if (wr && (addr == `CSR_PCCR_ALL || addr == PCCR_BASE + i)) begin
        m_cnt[i] = wd;
      end
    end
    m_idv_q = perf.id_valid;
    m_inc_q = new_inc;
    if (wr && addr == `CSR_PCER) m_pcer = wd[7:0];
    if (wr && addr == `CSR_PCMR) m_pcmr = wd[1:0];
    if (wr && addr == `CSR_MTVEC) m_mtvec = wd[31:8];
    if (trap.save_cause) begin
      m_mpie   = (m_priv == 2'b00) ? m_uie : m_mie;
      m_mie    = 1'b0;
      m_mpp    = m_priv;
      m_priv   = 2'b11;
      m_mepc   = trap.save_if ? trap.pc_if : trap.pc_id;
      m_mcause = trap.cause;
    end else begin
      if (trap.restore_mret) begin
        if (m_mpp == 2'b00) begin
          m_uie  = m_mpie;
          m_priv = 2'b00;
        end else begin
          m_mie  = m_mpie;
          m_priv = 2'b11;
        end
        m_mpie = 1'b1;
        m_mpp  = 2'b00;
      end else if (wr && addr == `CSR_MSTATUS) begin
        m_uie  = wd[`MSTATUS_UIE];
        m_mie  = wd[`MSTATUS_MIE];
        m_upie = wd[`MSTATUS_UPIE];
        m_mpie = wd[`MSTATUS_MPIE];
        m_mpp  = wd[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO];
      end else if (wr && addr == `CSR_USTATUS) begin
        m_uie  = wd[`MSTATUS_UIE];
        m_upie = wd[`MSTATUS_UPIE];
      end
      if (wr && addr == `CSR_MEPC) m_mepc = wd;
      if (wr && addr == `CSR_MCAUSE) m_mcause = wd[5:0];
    end
  endtask

  // called at edge + 1 ns with the inputs already driven
  task automatic run_cycle();
    #2;
    last_rdata = csr_rdata;
    check_val("csr_rdata_o", csr_rdata, exp_rdata(acc, addr));
    check_val("priv_lvl_o", priv_lvl, m_priv);
    check_val("epc_o", epc, m_mepc);
    check_val("mtvec_o", mtvec, m_mtvec);
    check_val("m_irq_enable_o", m_irq_en, m_mie && m_priv == 2'b11);
    check_val("u_irq_enable_o", u_irq_en, m_uie && m_priv == 2'b00);
    @(posedge clk);
    model_update();
    #1;
  endtask

  task automatic write_csr(input logic [11:0] ad, input csr_op_t o, input logic [31:0] d);
    acc   = 1'b1;
    addr  = ad;
    op    = o;
    wdata = d;
    run_cycle();
  endtask

  task automatic read_csr(input logic [11:0] ad);
    write_csr(ad, CSR_OP_NONE, $urandom);
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err_start);
    test_err_start = err_cnt;
  endtask

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  initial begin
    #((BUDGET + MARGIN) * CLK_PERIOD);
    $display("timeout: tests did not finish within %0d cycles", BUDGET + MARGIN);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial begin
    acc = 1'b0;
    addr = '0;
    op = CSR_OP_NONE;
    wdata = '0;
    trap = '0;
    perf = '0;
    err_cnt = 0;
    check_cnt = 0;
    test_cnt = 0;
    test_err_start = 0;
    // model at its reset values
    m_priv = 2'b11;
    {m_uie, m_mie, m_upie, m_mpie} = 4'b0;
    m_mpp = 2'b11;
    m_mepc = '0;
    m_mcause = '0;
    m_mtvec = '0;
    m_pcer = '0;
    m_pcmr = `PCMR_RESET;
    m_idv_q = 1'b0;
    m_inc_q = '0;
    for (int i = 0; i < 8; i++) m_cnt[i] = '0;
    seed_ret = $urandom(32'hdf5b);
    wait (rst_n);
    @(posedge clk);
    #1;

    // reset values
    read_csr(`CSR_MSTATUS);
    check_val("mstatus", last_rdata, 32'h1800);
    read_csr(`CSR_PRIVLV);
    check_val("privlv", last_rdata, 32'h3);
    read_csr(`CSR_PCMR);
    check_val("pcmr", last_rdata, 32'h3);
    read_csr(`CSR_MEPC);
    check_val("mepc", last_rdata, 32'h0);
    read_csr(`CSR_MCAUSE);
    check_val("mcause", last_rdata, 32'h0);
    read_csr(`CSR_MTVEC);
    check_val("mtvec", last_rdata, 32'h0);
    for (int i = 0; i < 9; i++) begin
      read_csr(PCCR_BASE + i);
      check_val("pccr", last_rdata, 32'h0);
    end
    read_csr(`CSR_MHARTID);
    check_val("mhartid", last_rdata, HARTID_EXP);
    read_csr(`CSR_UHARTID);
    check_val("uhartid", last_rdata, HARTID_EXP);
    check_val("m_irq_enable_o", m_irq_en, 1'b0);
    check_val("u_irq_enable_o", u_irq_en, 1'b0);
    finish_test("reset values");

    // random register traffic, access low now and then
    for (int n = 0; n < 200; n++) begin
      acc   = ($urandom_range(4, 0) != 0);
      addr  = reg_addrs[$urandom_range(4, 0)];
      op    = csr_op_t'($urandom_range(3, 0));
      wdata = $urandom;
      run_cycle();
    end
    finish_test("csr read/write");

    // mret into U with mpp = U and mpie = 1
    write_csr(`CSR_MSTATUS, CSR_OP_WRITE, 32'h0000_0081);
    acc = 1'b0;
    trap.restore_mret = 1'b1;
    run_cycle();
    trap = '0;
    check_val("priv_lvl_o after mret", priv_lvl, PRIV_LVL_U);
    check_val("u_irq_enable_o after mret", u_irq_en, 1'b1);
    // random traps, mret and software writes in the same cycle
    for (int n = 0; n < 300; n++) begin
      int r;
      r = $urandom_range(9, 0);
      trap = '0;
      if (r < 3) begin
        trap.save_cause   = 1'b1;
        trap.save_if      = $urandom_range(1, 0);
        trap.save_id      = !trap.save_if;
        trap.restore_mret = (r == 0);
        trap.cause        = $urandom_range(63, 0);
        trap.pc_if        = $urandom;
        trap.pc_id        = $urandom;
      end else if (r < 6) begin
        trap.restore_mret = 1'b1;
      end
      acc   = ($urandom_range(3, 0) != 0);
      addr  = trap_addrs[$urandom_range(4, 0)];
      op    = csr_op_t'($urandom_range(3, 0));
      wdata = $urandom;
      run_cycle();
    end
    trap = '0;
    finish_test("traps and mret");

    // counters with random mask and events
    write_csr(`CSR_PCMR, CSR_OP_WRITE, 32'h3);
    write_csr(`CSR_PCCR_ALL, CSR_OP_WRITE, 32'h0);
    write_csr(`CSR_PCER, CSR_OP_WRITE, $urandom_range(255, 0));
    for (int n = 0; n < 240; n++) begin
      perf = perf_events_t'($urandom_range(255, 0));
      acc  = 1'b1;
      op   = CSR_OP_NONE;
      addr = PCCR_BASE + $urandom_range(7, 0);
      wdata = $urandom;
      if (n == 60) begin
        op   = CSR_OP_WRITE;
        addr = `CSR_PCER;
      end else if (n == 100 || n == 160) begin
        // global enable off, then back on
        op    = CSR_OP_WRITE;
        addr  = `CSR_PCMR;
        wdata = (n == 100) ? 32'h2 : 32'h3;
      end
      run_cycle();
    end
    // cycle counter enabled so the global enable decides
    write_csr(`CSR_PCER, CSR_OP_SET, 32'h1);
    write_csr(`CSR_PCMR, CSR_OP_WRITE, 32'h2);
    // let the event pipeline drain
    repeat (3) read_csr(PCCR_BASE);
    held = m_cnt[0];
    repeat (10) read_csr(PCCR_BASE);
    check_val("pccr0 held", last_rdata, held);
    write_csr(`CSR_PCMR, CSR_OP_WRITE, 32'h3);
    for (int i = 0; i < 8; i++) read_csr(PCCR_BASE + i);
    finish_test("counters");

    // saturate and wrap at all ones
    perf = '1;
    write_csr(`CSR_PCER, CSR_OP_WRITE, 32'hff);
    write_csr(`CSR_PCCR_ALL, CSR_OP_WRITE, 32'hffff_ffff);
    repeat (3) read_csr(PCCR_BASE);
    check_val("pccr0 saturated", last_rdata, 32'hffff_ffff);
    write_csr(`CSR_PCMR, CSR_OP_WRITE, 32'h1);
    write_csr(`CSR_PCCR_ALL, CSR_OP_WRITE, 32'hffff_ffff);
    read_csr(PCCR_BASE);
    check_val("pccr0 preset", last_rdata, 32'hffff_ffff);
    read_csr(PCCR_BASE);
    check_val("pccr0 wrapped", last_rdata, 32'h0);
    // whole-bank load
    write_csr(`CSR_PCCR_ALL, CSR_OP_WRITE, $urandom);
    for (int i = 0; i < 8; i++) read_csr(PCCR_BASE + i);
    perf = '0;
    for (int n = 0; n < 30; n++) begin
      write_csr($urandom_range(1, 0) ? `CSR_PCER : `CSR_PCMR,
                $urandom_range(1, 0) ? CSR_OP_SET : CSR_OP_CLEAR, $urandom);
    end
    finish_test("saturation and bank");

    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== sim/tb_clk_gen.sv ====
////////////////////////////////////////
// clock and reset for the testbench
// reset low for RESET_CYCLES rising edges
////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 4
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release 1 ns after the last reset edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== trap/priv_trap_fsm.sv ====
////////////////////////////////////////
// privilege level and mstatus bits
// traps and mret win over csr writes
////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module priv_trap_fsm import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  trap_req_t            trap_i,
  input  csr_sel_t             sel_i,
  input  logic                 wr_en_i,
  input  logic [`CSR_XLEN-1:0] wdata_i,
  output mstatus_t             mstatus_o,
  output priv_lvl_t            priv_lvl_o,
  output logic                 m_irq_enable_o,
  output logic                 u_irq_enable_o
);

  priv_lvl_t priv_lvl_q;
  priv_lvl_t priv_lvl_n;
  mstatus_t  mstatus_q;
  mstatus_t  mstatus_n;

  ////////////////////////////////////////
  // next state
  ////////////////////////////////////////

  always_comb begin
    priv_lvl_n = priv_lvl_q;
    mstatus_n  = mstatus_q;
    if (trap_i.save_cause) begin
      // every trap lands in M
      priv_lvl_n = PRIV_LVL_M;
      case (priv_lvl_q)
        PRIV_LVL_U: mstatus_n.mpie = mstatus_q.uie;
        default:    mstatus_n.mpie = mstatus_q.mie;
      endcase
      mstatus_n.mie = 1'b0;
      mstatus_n.mpp = priv_lvl_q;
    end else if (trap_i.restore_mret) begin
      // mpp values other than U return to M
      case (mstatus_q.mpp)
        PRIV_LVL_U: begin
          mstatus_n.uie = mstatus_q.mpie;
          priv_lvl_n    = PRIV_LVL_U;
        end
        default: begin
          mstatus_n.mie = mstatus_q.mpie;
          priv_lvl_n    = PRIV_LVL_M;
        end
      endcase
      mstatus_n.mpie = 1'b1;
      mstatus_n.mpp  = PRIV_LVL_U;
    end else if (wr_en_i && sel_i.mstatus) begin
      mstatus_n.uie  = wdata_i[`MSTATUS_UIE];
      mstatus_n.mie  = wdata_i[`MSTATUS_MIE];
      mstatus_n.upie = wdata_i[`MSTATUS_UPIE];
      mstatus_n.mpie = wdata_i[`MSTATUS_MPIE];
      mstatus_n.mpp  = priv_lvl_t'(wdata_i[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO]);
    end else if (wr_en_i && sel_i.ustatus) begin
      // user view, machine bits untouched
      mstatus_n.uie  = wdata_i[`MSTATUS_UIE];
      mstatus_n.upie = wdata_i[`MSTATUS_UPIE];
    end
  end

  ////////////////////////////////////////
  // state registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      priv_lvl_q <= PRIV_LVL_M;
      mstatus_q  <= '{uie: 1'b0, mie: 1'b0, upie: 1'b0, mpie: 1'b0, mpp: PRIV_LVL_M};
    end else begin
      priv_lvl_q <= priv_lvl_n;
      mstatus_q  <= mstatus_n;
    end
  end

  assign mstatus_o  = mstatus_q;
  assign priv_lvl_o = priv_lvl_q;

  // enable only counts in its own mode
  assign m_irq_enable_o = mstatus_q.mie && (priv_lvl_q == PRIV_LVL_M);
  assign u_irq_enable_o = mstatus_q.uie && (priv_lvl_q == PRIV_LVL_U);

endmodule

// ==== trap/trap_regs.sv ====
////////////////////////////////////////
// mepc, mcause and mtvec
// trap capture beats a csr write
////////////////////////////////////////

`timescale 1ns/1ps

module trap_regs import csr_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  trap_req_t   trap_i,
  input  csr_sel_t    sel_i,
  input  logic        wr_en_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] mepc_o,
  output logic [5:0]  mcause_o,
  output logic [23:0] mtvec_o
);

  logic [31:0] exc_pc;

  // pc of the faulting stage, id when neither flag is set
  assign exc_pc = trap_i.save_if ? trap_i.pc_if : trap_i.pc_id;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mepc_o   <= '0;
      mcause_o <= '0;
    end else if (trap_i.save_cause) begin
      mepc_o   <= exc_pc;
      mcause_o <= trap_i.cause;
    end else begin
      if (wr_en_i && sel_i.mepc) begin
        mepc_o <= wdata_i;
      end
      // interrupt flag and 5-bit code
      if (wr_en_i && sel_i.mcause) begin
        mcause_o <= {wdata_i[5], wdata_i[4:0]};
      end
    end
  end

  // traps never touch mtvec
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mtvec_o <= '0;
    end else if (wr_en_i && sel_i.mtvec) begin
      // 256-byte aligned base
      mtvec_o <= wdata_i[31:8];
    end
  end

endmodule

// ==== verilog/csr_op_decode.sv ====
////////////////////////////////////////
// csr address decode and read mux
// reads are combinational, 0 when idle
// or the address is not implemented
////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_op_decode import csr_pkg::*; (
  input  logic                   csr_access_i,
  input  logic [11:0]            csr_addr_i,
  input  csr_op_t                csr_op_i,
  input  logic [`CSR_XLEN-1:0]   csr_wdata_i,
  input  logic [3:0]             core_id_i,
  input  logic [5:0]             cluster_id_i,
  // register state
  input  mstatus_t               mstatus_i,
  input  priv_lvl_t              priv_lvl_i,
  input  logic [`CSR_XLEN-1:0]   mepc_i,
  input  logic [5:0]             mcause_i,
  input  logic [23:0]            mtvec_i,
  input  logic [`PERF_N_CNT-1:0] pcer_i,
  input  logic [1:0]             pcmr_i,
  input  logic [`CSR_XLEN-1:0]   pccr_rdata_i,
  // to the register blocks
  output csr_sel_t               sel_o,
  output logic                   wr_en_o,
  output logic [`CSR_XLEN-1:0]   wdata_o,
  output logic [`CSR_XLEN-1:0]   csr_rdata_o
);

  // 0x780..0x79F share the upper seven address bits
  localparam logic [11:0] PCCR_BASE = `CSR_PCCR_BASE;

  logic [`CSR_XLEN-1:0] hartid;

  // cluster in 10:5, core in 3:0
  assign hartid = {21'b0, cluster_id_i, 1'b0, core_id_i};

  ////////////////////////////////////////
  // address decode and read mux
  ////////////////////////////////////////

  always_comb begin
    sel_o       = '0;
    csr_rdata_o = '0;
    if (csr_access_i) begin
      case (csr_addr_i)
        `CSR_USTATUS: begin
          sel_o.ustatus = 1'b1;
          csr_rdata_o[`MSTATUS_UIE]  = mstatus_i.uie;
          csr_rdata_o[`MSTATUS_UPIE] = mstatus_i.upie;
        end
        `CSR_MSTATUS: begin
          sel_o.mstatus = 1'b1;
          csr_rdata_o[`MSTATUS_UIE]  = mstatus_i.uie;
          csr_rdata_o[`MSTATUS_MIE]  = mstatus_i.mie;
          csr_rdata_o[`MSTATUS_UPIE] = mstatus_i.upie;
          csr_rdata_o[`MSTATUS_MPIE] = mstatus_i.mpie;
          csr_rdata_o[`MSTATUS_MPP_HI:`MSTATUS_MPP_LO] = mstatus_i.mpp;
        end
        `CSR_MTVEC: begin
          sel_o.mtvec = 1'b1;
          csr_rdata_o = {mtvec_i, 8'h00};
        end
        `CSR_MEPC: begin
          sel_o.mepc  = 1'b1;
          csr_rdata_o = mepc_i;
        end
        `CSR_MCAUSE: begin
          sel_o.mcause = 1'b1;
          // interrupt flag moves up to the msb
          csr_rdata_o  = {mcause_i[5], 26'b0, mcause_i[4:0]};
        end
        // hart id and its user-space copy
        `CSR_MHARTID, `CSR_UHARTID: csr_rdata_o = hartid;
        `CSR_PRIVLV: csr_rdata_o = {30'b0, priv_lvl_i};
        // id registers, no allocated values
        `CSR_MISA, `CSR_MVENDORID, `CSR_MARCHID, `CSR_MIMPID: csr_rdata_o = '0;
        `CSR_PCER: begin
          sel_o.pcer = 1'b1;
          csr_rdata_o[`PERF_N_CNT-1:0] = pcer_i;
        end
        `CSR_PCMR: begin
          sel_o.pcmr = 1'b1;
          csr_rdata_o[1:0] = pcmr_i;
        end
        // whole bank, write only
        `CSR_PCCR_ALL: sel_o.pccr_all = 1'b1;
        default: begin
          // single counter window
          if (csr_addr_i[11:5] == PCCR_BASE[11:5]) begin
            sel_o.pccr    = 1'b1;
            sel_o.cnt_idx = csr_addr_i[4:0];
            csr_rdata_o   = pccr_rdata_i;
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // write data resolve
  ////////////////////////////////////////

  assign wr_en_o = csr_access_i && (csr_op_i != CSR_OP_NONE);

  // set and clear work on the current read value
  always_comb begin
    case (csr_op_i)
      CSR_OP_SET:   wdata_o = csr_rdata_o | csr_wdata_i;
      CSR_OP_CLEAR: wdata_o = csr_rdata_o & ~csr_wdata_i;
      default:      wdata_o = csr_wdata_i;
    endcase
  end

endmodule

// ==== verilog/csr_unit_top.sv ====
////////////////////////////////////////
// csr unit, all accesses finish in one
// cycle, no back-pressure
////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_macros.svh"

module csr_unit_top import csr_pkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  // csr access port
  input  logic                     csr_access_i,
  input  logic [11:0]              csr_addr_i,
  input  csr_op_t                  csr_op_i,
  input  logic [`CSR_XLEN-1:0]     csr_wdata_i,
  output logic [`CSR_XLEN-1:0]     csr_rdata_o,
  // controller side
  input  trap_req_t                trap_i,
  input  perf_events_t             perf_i,
  input  logic [3:0]               core_id_i,
  input  logic [5:0]               cluster_id_i,
  output priv_lvl_t                priv_lvl_o,
  output logic                     m_irq_enable_o,
  output logic                     u_irq_enable_o,
  output logic [`CSR_XLEN-1:0]     epc_o,
  output logic [23:0]              mtvec_o
);

  // decoder outputs
  csr_sel_t                  sel;
  logic                      wr_en;
  logic [`CSR_XLEN-1:0]      wdata;

  // register state back to the read mux
  mstatus_t                  mstatus;
  logic [5:0]                mcause;
  logic [`PERF_N_CNT-1:0]    pcer;
  logic [1:0]                pcmr;
  logic [`CSR_XLEN-1:0]      pccr_rdata;

  csr_op_decode u_decode (
    .csr_access_i (csr_access_i),
    .csr_addr_i   (csr_addr_i),
    .csr_op_i     (csr_op_i),
    .csr_wdata_i  (csr_wdata_i),
    .core_id_i    (core_id_i),
    .cluster_id_i (cluster_id_i),
    .mstatus_i    (mstatus),
    .priv_lvl_i   (priv_lvl_o),
    .mepc_i       (epc_o),
    .mcause_i     (mcause),
    .mtvec_i      (mtvec_o),
    .pcer_i       (pcer),
    .pcmr_i       (pcmr),
    .pccr_rdata_i (pccr_rdata),
    .sel_o        (sel),
    .wr_en_o      (wr_en),
    .wdata_o      (wdata),
    .csr_rdata_o  (csr_rdata_o)
  );

  priv_trap_fsm u_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .trap_i         (trap_i),
    .sel_i          (sel),
    .wr_en_i        (wr_en),
    .wdata_i        (wdata),
    .mstatus_o      (mstatus),
    .priv_lvl_o     (priv_lvl_o),
    .m_irq_enable_o (m_irq_enable_o),
    .u_irq_enable_o (u_irq_enable_o)
  );

  // mepc goes straight out as epc
  trap_regs u_trap_regs (
    .clk      (clk),
    .rst_n    (rst_n),
    .trap_i   (trap_i),
    .sel_i    (sel),
    .wr_en_i  (wr_en),
    .wdata_i  (wdata),
    .mepc_o   (epc_o),
    .mcause_o (mcause),
    .mtvec_o  (mtvec_o)
  );

  perf_counters u_perf (
    .clk          (clk),
    .rst_n        (rst_n),
    .perf_i       (perf_i),
    .sel_i        (sel),
    .wr_en_i      (wr_en),
    .wdata_i      (wdata),
    .pcer_o       (pcer),
    .pcmr_o       (pcmr),
    .pccr_rdata_o (pccr_rdata)
  );

endmodule
